//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_loader
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/loader_pkg.sv
src/download_fsm.sv
src/word_packer.sv
src/media_tracker.sv
src/loader_top.sv
tests/tb_loader.sv

//--- src/download_fsm.sv
//==========================================================
// Download FSM: registered image kind, executable start
// pulse and CD end-of-download event
//==========================================================
`timescale 1ns/10ps

module download_fsm (
	input  logic                              clk_1x,
	input  logic                              reset,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic [loader_pkg::ADDR_W-1:0]     ioctl_addr,
	output logic                              dl_bios,
	output logic                              dl_exe,
	output logic                              dl_cd,
	output logic                              exe_start,
	output logic                              cd_done,
	output logic [loader_pkg::CD_SIZE_W-1:0]  cd_end_addr
);
	import loader_pkg::*;

	logic [1:0] state;
	logic [1:0] state_next;
	logic       dl_exe_q;
	logic       dl_cd_q;
	logic       exe_fall;
	logic       cd_fall;

	// Kind comes straight from the flag and the index compare
	always_comb begin
		state_next = ST_IDLE;
		if (ioctl_download) begin
			if (ioctl_index == IDX_BIOS) begin
				state_next = ST_BIOS;
			end else if (ioctl_index == IDX_EXE) begin
				state_next = ST_EXE;
			end else if (ioctl_index[5:0] == IDX_CD) begin
				state_next = ST_CD;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign dl_bios = (state == ST_BIOS);
	assign dl_exe  = (state == ST_EXE);
	assign dl_cd   = (state == ST_CD);

	// =========================================================
	// End-of-download events
	// =========================================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			dl_exe_q  <= 1'b0;
			dl_cd_q   <= 1'b0;
			exe_fall  <= 1'b0;
			cd_fall   <= 1'b0;
			exe_start <= 1'b0;
			cd_done   <= 1'b0;
		end else begin
			dl_exe_q  <= dl_exe;
			dl_cd_q   <= dl_cd;
			// One extra stage after the falling edge
			exe_fall  <= dl_exe_q & ~dl_exe;
			cd_fall   <= dl_cd_q & ~dl_cd;
			exe_start <= exe_fall;
			cd_done   <= cd_fall;
		end
	end

	// Final host address is the CD size, held until cd_done
	always_ff @(posedge clk_1x) begin
		if (dl_cd_q && !dl_cd) begin
			cd_end_addr <= CD_SIZE_W'(ioctl_addr);
		end
	end

endmodule

//--- src/loader_pkg.sv
//==========================================================
// Media loader shared definitions: bus widths, RAM base
// addresses, download index codes and mount slot positions
//==========================================================
package loader_pkg;

	// =========================================================
	// Widths
	// =========================================================
	localparam int HOST_DATA_W = 16;
	localparam int RAM_DATA_W  = 32;
	localparam int ADDR_W      = 27;
	localparam int CD_SIZE_W   = 30;
	localparam int IMG_SIZE_W  = 64;

	// =========================================================
	// RAM byte addresses per image kind
	// =========================================================
	localparam logic [ADDR_W-1:0] BIOS_BASE = ADDR_W'(2097152);
	localparam logic [ADDR_W-1:0] EXE_BASE  = ADDR_W'(4194304);

	// Download index codes
	localparam logic [7:0] IDX_BIOS = 8'd0;
	localparam logic [7:0] IDX_EXE  = 8'd1;
	// CD matches on the low 6 bits only
	localparam logic [5:0] IDX_CD   = 6'd2;

	// Bit positions in the mount strobe vector
	localparam int SLOT_CD    = 1;
	localparam int SLOT_CARD1 = 2;
	localparam int SLOT_CARD2 = 3;

	// Download FSM state codes
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BIOS = 2'd1;
	localparam logic [1:0] ST_EXE  = 2'd2;
	localparam logic [1:0] ST_CD   = 2'd3;

endpackage

//--- src/loader_top.sv
//==========================================================
// Media loader top level: download FSM, word packer and
// media tracker
//==========================================================
`timescale 1ns/10ps

module loader_top (
	input  logic                               clk_1x,
	input  logic                               reset,
	// Host download port
	input  logic                               ioctl_download,
	input  logic [7:0]                         ioctl_index,
	input  logic                               ioctl_wr,
	input  logic [loader_pkg::ADDR_W-1:0]      ioctl_addr,
	input  logic [loader_pkg::HOST_DATA_W-1:0] ioctl_dout,
	output logic                               ioctl_wait,
	// RAM write ports
	output logic                               ram_wr,
	output logic                               ram2_wr,
	output logic [loader_pkg::ADDR_W-1:0]      ram_addr,
	output logic [loader_pkg::RAM_DATA_W-1:0]  ram_data,
	input  logic                               ram_ack,
	input  logic                               ram2_ack,
	// Mounts and card requests
	input  logic [3:0]                         img_mounted,
	input  logic [loader_pkg::IMG_SIZE_W-1:0]  img_size,
	input  logic                               card_load_req,
	input  logic                               card_save_req,
	input  logic                               osd_open,
	input  logic                               autosave,
	output logic                               exe_start,
	output logic                               has_cd,
	output logic                               cd_from_sd,
	output logic [loader_pkg::CD_SIZE_W-1:0]   cd_size,
	output logic                               card1_present,
	output logic                               card2_present,
	output logic                               card1_load,
	output logic                               card2_load,
	output logic                               card_save
);
	import loader_pkg::*;

	logic                 dl_bios;
	logic                 dl_exe;
	logic                 dl_cd;
	logic                 cd_done;
	logic [CD_SIZE_W-1:0] cd_end_addr;

	download_fsm fsm0 (
		.clk_1x         (clk_1x),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.dl_bios        (dl_bios),
		.dl_exe         (dl_exe),
		.dl_cd          (dl_cd),
		.exe_start      (exe_start),
		.cd_done        (cd_done),
		.cd_end_addr    (cd_end_addr)
	);

	word_packer packer0 (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.dl_bios    (dl_bios),
		.dl_exe     (dl_exe),
		.dl_cd      (dl_cd),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.ram_ack    (ram_ack),
		.ram2_ack   (ram2_ack),
		.ioctl_wait (ioctl_wait),
		.ram_wr     (ram_wr),
		.ram2_wr    (ram2_wr),
		.ram_addr   (ram_addr),
		.ram_data   (ram_data)
	);

	media_tracker media0 (
		.clk_1x        (clk_1x),
		.reset         (reset),
		.cd_done       (cd_done),
		.cd_end_addr   (cd_end_addr),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.card_load_req (card_load_req),
		.card_save_req (card_save_req),
		.osd_open      (osd_open),
		.autosave      (autosave),
		.has_cd        (has_cd),
		.cd_from_sd    (cd_from_sd),
		.cd_size       (cd_size),
		.card1_present (card1_present),
		.card2_present (card2_present),
		.card1_load    (card1_load),
		.card2_load    (card2_load),
		.card_save     (card_save)
	);

endmodule

//--- src/media_tracker.sv
//==========================================================
// Media tracker: CD and memory-card mount state, CD size,
// card load and save request pulses
//==========================================================
`timescale 1ns/10ps

module media_tracker (
	input  logic                               clk_1x,
	input  logic                               reset,
	input  logic                               cd_done,
	input  logic [loader_pkg::CD_SIZE_W-1:0]   cd_end_addr,
	input  logic [3:0]                         img_mounted,
	input  logic [loader_pkg::IMG_SIZE_W-1:0]  img_size,
	input  logic                               card_load_req,
	input  logic                               card_save_req,
	input  logic                               osd_open,
	input  logic                               autosave,
	output logic                               has_cd,
	output logic                               cd_from_sd,
	output logic [loader_pkg::CD_SIZE_W-1:0]   cd_size,
	output logic                               card1_present,
	output logic                               card2_present,
	output logic                               card1_load,
	output logic                               card2_load,
	output logic                               card_save
);
	import loader_pkg::*;

	logic size_nonzero;
	logic autosave_req;
	logic load_req_q;
	logic save_req_q;
	logic autosave_q;
	logic load_edge;
	logic save_edge;

	assign size_nonzero = |img_size;
	// Autosave fires when the menu opens with autosave on
	assign autosave_req = osd_open & autosave;
	assign load_edge    = card_load_req & ~load_req_q;
	assign save_edge    = (card_save_req & ~save_req_q) | (autosave_req & ~autosave_q);

	// =========================================================
	// CD state
	// =========================================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			has_cd     <= 1'b0;
			cd_from_sd <= 1'b0;
		end else begin
			if (cd_done) begin
				has_cd     <= 1'b1;
				cd_from_sd <= 1'b0;
			end
			// A mounted image takes over from a download
			if (img_mounted[SLOT_CD]) begin
				has_cd <= size_nonzero;
				if (size_nonzero) begin
					cd_from_sd <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (img_mounted[SLOT_CD] && size_nonzero) begin
			cd_size <= img_size[CD_SIZE_W-1:0];
		end else if (cd_done) begin
			cd_size <= cd_end_addr;
		end
	end

	// =========================================================
	// Memory cards
	// =========================================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			card1_present <= 1'b0;
			card2_present <= 1'b0;
			card1_load    <= 1'b0;
			card2_load    <= 1'b0;
			card_save     <= 1'b0;
			load_req_q    <= 1'b0;
			save_req_q    <= 1'b0;
			autosave_q    <= 1'b0;
		end else begin
			load_req_q <= card_load_req;
			save_req_q <= card_save_req;
			autosave_q <= autosave_req;
			if (img_mounted[SLOT_CARD1]) begin
				card1_present <= size_nonzero;
			end
			if (img_mounted[SLOT_CARD2]) begin
				card2_present <= size_nonzero;
			end
			// Fresh mount or a reload request
			card1_load <= load_edge | (img_mounted[SLOT_CARD1] & size_nonzero);
			card2_load <= load_edge | (img_mounted[SLOT_CARD2] & size_nonzero);
			card_save  <= save_edge;
		end
	end

endmodule

//--- src/word_packer.sv
//==========================================================
// Word packer: joins host half-words into 32-bit RAM writes
// and holds the host wait line until the RAM acknowledges
//==========================================================
`timescale 1ns/10ps

module word_packer (
	input  logic                                clk_1x,
	input  logic                                reset,
	input  logic                                dl_bios,
	input  logic                                dl_exe,
	input  logic                                dl_cd,
	input  logic                                ioctl_wr,
	input  logic [loader_pkg::ADDR_W-1:0]       ioctl_addr,
	input  logic [loader_pkg::HOST_DATA_W-1:0]  ioctl_dout,
	input  logic                                ram_ack,
	input  logic                                ram2_ack,
	output logic                                ioctl_wait,
	output logic                                ram_wr,
	output logic                                ram2_wr,
	output logic [loader_pkg::ADDR_W-1:0]       ram_addr,
	output logic [loader_pkg::RAM_DATA_W-1:0]   ram_data
);
	import loader_pkg::*;

	logic              dl_any;
	logic              wr_low;
	logic              wr_high;
	logic [ADDR_W-1:0] base_addr;

	assign dl_any  = dl_bios | dl_exe | dl_cd;
	assign wr_low  = dl_any & ioctl_wr & ~ioctl_addr[1];
	assign wr_high = dl_any & ioctl_wr & ioctl_addr[1];

	// CD data lands unshifted on the second port
	always_comb begin
		if (dl_bios) begin
			base_addr = BIOS_BASE;
		end else if (dl_exe) begin
			base_addr = EXE_BASE;
		end else begin
			base_addr = '0;
		end
	end

	// =========================================================
	// Write strobes and wait handshake
	// =========================================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			ram_wr     <= 1'b0;
			ram2_wr    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			ram_wr  <= wr_high & (dl_bios | dl_exe);
			ram2_wr <= wr_high & dl_cd;
			if (!dl_any) begin
				ioctl_wait <= 1'b0;
			end else if (ram_ack || ram2_ack) begin
				ioctl_wait <= 1'b0;
			end else if (wr_high) begin
				ioctl_wait <= 1'b1;
			end
		end
	end

	// Low half sets the address, high half completes the data
	always_ff @(posedge clk_1x) begin
		if (wr_low) begin
			ram_data[HOST_DATA_W-1:0] <= ioctl_dout;
			ram_addr                  <= ioctl_addr + base_addr;
		end
		if (wr_high) begin
			ram_data[RAM_DATA_W-1:HOST_DATA_W] <= ioctl_dout;
		end
	end

endmodule

//--- tests/tb_loader.sv
//==========================================================
// Loader testbench: seeded random downloads, mounts and
// card requests checked against a queue model
//==========================================================
`timescale 1ns/10ps

module tb_loader;
	import loader_pkg::*;

	localparam int WAIT_LIMIT = 20;

	logic                   clk_1x;
	logic                   reset;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [ADDR_W-1:0]      ioctl_addr;
	logic [HOST_DATA_W-1:0] ioctl_dout;
	logic                   ioctl_wait;
	logic                   ram_wr;
	logic                   ram2_wr;
	logic [ADDR_W-1:0]      ram_addr;
	logic [RAM_DATA_W-1:0]  ram_data;
	logic                   ram_ack;
	logic                   ram2_ack;
	logic [3:0]             img_mounted;
	logic [IMG_SIZE_W-1:0]  img_size;
	logic                   card_load_req;
	logic                   card_save_req;
	logic                   osd_open;
	logic                   autosave;
	logic                   exe_start;
	logic                   has_cd;
	logic                   cd_from_sd;
	logic [CD_SIZE_W-1:0]   cd_size;
	logic                   card1_present;
	logic                   card2_present;
	logic                   card1_load;
	logic                   card2_load;
	logic                   card_save;

	// Model state
	logic [ADDR_W-1:0]      exp_addr_q[$];
	logic [RAM_DATA_W-1:0]  exp_data_q[$];
	logic                   exp_port_q[$];
	logic                   m_card1;
	logic                   m_card2;
	logic                   m_has_cd;
	logic                   m_cd_sd;
	logic                   m_size_known;
	logic [CD_SIZE_W-1:0]   m_cd_size;
	int                     errors;
	int                     checks;
	int                     writes_seen;

	loader_top dut0 (.*);

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	// =========================================================
	// Compare tasks
	// =========================================================
	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_size(input string name, input logic [CD_SIZE_W-1:0] expected,
			input logic [CD_SIZE_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_write(input string name, input logic [ADDR_W-1:0] exp_addr,
			input logic [RAM_DATA_W-1:0] exp_data, input logic [ADDR_W-1:0] act_addr,
			input logic [RAM_DATA_W-1:0] act_data);
		checks++;
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			errors++;
			$display("MISMATCH %s: expected %h/%h, actual %h/%h", name,
				exp_addr, exp_data, act_addr, act_data);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("ERROR: %s", what);
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %-10s ok", name);
		end else begin
			$display("test %-10s %0d errors", name, errors - errors_before);
		end
	endtask

	// Every RAM strobe must match the oldest outstanding word
	always @(negedge clk_1x) begin
		if (!reset && (ram_wr || ram2_wr)) begin
			writes_seen++;
			if (ram_wr && ram2_wr) begin
				note_failure("ram_wr and ram2_wr strobed in the same cycle");
			end else if (exp_addr_q.size() == 0) begin
				note_failure("RAM write strobe with no word outstanding");
			end else begin
				check_bit("ram2 port select", exp_port_q.pop_front(), ram2_wr);
				check_write("ram write", exp_addr_q.pop_front(), exp_data_q.pop_front(),
					ram_addr, ram_data);
			end
		end
	end

	// =========================================================
	// Host side
	// =========================================================
	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [HOST_DATA_W-1:0] data);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
	endtask

	task automatic run_download(input string name, input logic [7:0] index,
			input logic [ADDR_W-1:0] base, input logic to_cd);
		int                     words;
		int                     n;
		int                     lat;
		logic [ADDR_W-1:0]      addr;
		logic [HOST_DATA_W-1:0] lo;
		logic [HOST_DATA_W-1:0] hi;
		words          = 4 + int'($urandom % 13);
		addr           = ADDR_W'(($urandom % 64) * 4);
		writes_seen    = 0;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_1x);
		for (int i = 0; i < words; i++) begin
			lo = HOST_DATA_W'($urandom);
			hi = HOST_DATA_W'($urandom);
			host_write(addr, lo);
			repeat ($urandom % 3) @(negedge clk_1x);
			exp_addr_q.push_back(addr + base);
			exp_data_q.push_back({hi, lo});
			exp_port_q.push_back(to_cd);
			host_write(addr + ADDR_W'(2), hi);
			check_bit({name, " wait after word"}, 1'b1, ioctl_wait);
			// Random RAM latency, the host stays held throughout
			lat = int'($urandom % 7);
			for (int k = 0; k < lat; k++) begin
				@(negedge clk_1x);
				check_bit({name, " wait before ack"}, 1'b1, ioctl_wait);
			end
			if (to_cd) begin
				ram2_ack = 1'b1;
			end else begin
				ram_ack = 1'b1;
			end
			@(negedge clk_1x);
			ram_ack  = 1'b0;
			ram2_ack = 1'b0;
			n = 0;
			while (ioctl_wait && n < WAIT_LIMIT) begin
				@(negedge clk_1x);
				n++;
			end
			if (ioctl_wait) begin
				note_failure({name, ": ioctl_wait stayed high after the acknowledge"});
			end
			addr = addr + ADDR_W'(4);
		end
		ioctl_download = 1'b0;
		if (writes_seen != words || exp_addr_q.size() != 0) begin
			errors++;
			$display("MISMATCH %s write count: expected %0d, actual %0d", name,
				words, writes_seen);
		end
	endtask

	task automatic count_exe_start(input string name, input int expected);
		int pulses;
		int first;
		pulses = 0;
		first  = 0;
		for (int i = 1; i <= 8; i++) begin
			@(negedge clk_1x);
			if (exe_start) begin
				pulses++;
				if (first == 0) begin
					first = i;
				end
			end
		end
		if (pulses != expected) begin
			errors++;
			$display("MISMATCH %s exe_start pulses: expected %0d, actual %0d", name,
				expected, pulses);
		end else if (first > 4) begin
			note_failure({name, ": exe_start came later than 4 cycles after the end"});
		end
	endtask

	// =========================================================
	// Mounts and card requests
	// =========================================================
	task automatic mount_image(input int slot, input logic [IMG_SIZE_W-1:0] size);
		logic nz;
		nz          = (size != '0);
		img_mounted = 4'b0;
		img_mounted[slot] = 1'b1;
		img_size    = size;
		@(negedge clk_1x);
		img_mounted = 4'b0;
		if (slot == SLOT_CD) begin
			m_has_cd = nz;
			if (nz) begin
				m_cd_sd      = 1'b1;
				m_cd_size    = size[CD_SIZE_W-1:0];
				m_size_known = 1'b1;
			end
		end
		if (slot == SLOT_CARD1) begin
			m_card1 = nz;
		end
		if (slot == SLOT_CARD2) begin
			m_card2 = nz;
		end
		check_bit("card1_present", m_card1, card1_present);
		check_bit("card2_present", m_card2, card2_present);
		check_bit("has_cd", m_has_cd, has_cd);
		check_bit("cd_from_sd", m_cd_sd, cd_from_sd);
		if (m_size_known) begin
			check_size("cd_size", m_cd_size, cd_size);
		end
		check_bit("card1_load on mount", nz && slot == SLOT_CARD1, card1_load);
		check_bit("card2_load on mount", nz && slot == SLOT_CARD2, card2_load);
		@(negedge clk_1x);
		check_bit("card1_load after mount", 1'b0, card1_load);
		check_bit("card2_load after mount", 1'b0, card2_load);
	endtask

	task automatic run_requests(input int cycles);
		logic prev_load;
		logic prev_save;
		logic prev_auto;
		logic auto_now;
		prev_load = card_load_req;
		prev_save = card_save_req;
		prev_auto = osd_open & autosave;
		for (int i = 0; i < cycles; i++) begin
			if ($urandom % 4 == 0) begin
				card_load_req = ~card_load_req;
			end
			if ($urandom % 4 == 0) begin
				card_save_req = ~card_save_req;
			end
			if ($urandom % 3 == 0) begin
				osd_open = ~osd_open;
			end
			if ($urandom % 8 == 0) begin
				autosave = ~autosave;
			end
			auto_now = osd_open & autosave;
			@(negedge clk_1x);
			check_bit("card1_load on request", card_load_req & ~prev_load, card1_load);
			check_bit("card2_load on request", card_load_req & ~prev_load, card2_load);
			check_bit("card_save on request",
				(card_save_req & ~prev_save) | (auto_now & ~prev_auto), card_save);
			prev_load = card_load_req;
			prev_save = card_save_req;
			prev_auto = auto_now;
		end
	endtask

	// =========================================================
	// Test sequence
	// =========================================================
	initial begin
		int   base_err;
		int   n;
		void'($urandom(32'h1bcfd90e));
		errors         = 0;
		checks         = 0;
		writes_seen    = 0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ram_ack        = 1'b0;
		ram2_ack       = 1'b0;
		img_mounted    = 4'b0;
		img_size       = '0;
		card_load_req  = 1'b0;
		card_save_req  = 1'b0;
		osd_open       = 1'b0;
		autosave       = 1'b0;
		m_card1        = 1'b0;
		m_card2        = 1'b0;
		m_has_cd       = 1'b0;
		m_cd_sd        = 1'b0;
		m_size_known   = 1'b0;
		m_cd_size      = '0;
		repeat (8) @(negedge clk_1x);
		reset = 1'b0;
		@(negedge clk_1x);

		base_err = errors;
		check_bit("outputs low after reset", 1'b0, |{ioctl_wait, ram_wr, ram2_wr, exe_start,
			has_cd, cd_from_sd, card1_present, card2_present, card1_load, card2_load,
			card_save});
		end_test("reset", base_err);

		base_err = errors;
		run_download("bios", IDX_BIOS, BIOS_BASE, 1'b0);
		count_exe_start("bios", 0);
		end_test("bios", base_err);

		base_err = errors;
		run_download("exe", IDX_EXE, EXE_BASE, 1'b0);
		count_exe_start("exe", 1);
		end_test("exe", base_err);

		// A mounted disc first, so the download end must clear cd_from_sd
		base_err = errors;
		mount_image(SLOT_CD, {32'($urandom), 32'($urandom) | 32'd1});
		run_download("cd", {2'($urandom), IDX_CD}, ADDR_W'(0), 1'b1);
		n = 0;
		while (cd_from_sd && n < WAIT_LIMIT) begin
			@(negedge clk_1x);
			n++;
		end
		if (cd_from_sd) begin
			note_failure("cd_from_sd did not clear after the CD download ended");
		end
		m_has_cd     = 1'b1;
		m_cd_sd      = 1'b0;
		m_cd_size    = CD_SIZE_W'(ioctl_addr);
		check_bit("has_cd after download", 1'b1, has_cd);
		check_size("cd_size after download", m_cd_size, cd_size);
		end_test("cd", base_err);

		base_err = errors;
		for (int i = 0; i < 24; i++) begin
			if ($urandom % 4 == 0) begin
				mount_image(SLOT_CD + int'($urandom % 3), '0);
			end else begin
				mount_image(SLOT_CD + int'($urandom % 3), {32'($urandom), 32'($urandom)});
			end
		end
		end_test("mounts", base_err);

		base_err = errors;
		run_requests(200);
		end_test("requests", base_err);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
